//--- hw/alu.sv
// Arithmetic and logic unit with a zero flag for branch compares
module alu (
	input  logic [31:0]         a,
	input  logic [31:0]         b,
	input  rvPkg::aluOperationT op,
	output logic [31:0]         result,
	output logic                zero
);

	always_comb begin
		case (op)
			rvPkg::aluAdd: result = a + b;
			rvPkg::aluSub: result = a - b;
			rvPkg::aluAnd: result = a & b;
			rvPkg::aluOr:  result = a | b;
			rvPkg::aluXor: result = a ^ b;
			rvPkg::aluSlt: begin
				// Signed compare
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == 32'd0); // Equal operands under SUB

endmodule

//--- hw/aluControl.sv
// Second-level ALU decoder from class and funct fields to a single operation
module aluControl (
	input  rvPkg::aluClassT     aluClass,
	input  logic [2:0]          funct3,
	input  logic                funct7b5, // SUB select in R form
	output rvPkg::aluOperationT aluOp
);

	logic isImm; // I form has no funct7, imm bit 10 must not pick SUB

	assign isImm = (aluClass == rvPkg::aluClassI);

	always_comb begin
		case (aluClass)
			rvPkg::aluClassAdd:    aluOp = rvPkg::aluAdd; // Addresses, LUI, AUIPC
			rvPkg::aluClassBranch: aluOp = rvPkg::aluSub; // Zero flag means equal
			rvPkg::aluClassR, rvPkg::aluClassI: begin
				case (funct3)
					rvPkg::funct3Add: begin
						if (funct7b5 && !isImm)
							aluOp = rvPkg::aluSub;
						else
							aluOp = rvPkg::aluAdd;
					end
					rvPkg::funct3Slt: aluOp = rvPkg::aluSlt;
					rvPkg::funct3Xor: aluOp = rvPkg::aluXor;
					rvPkg::funct3Or:  aluOp = rvPkg::aluOr;
					rvPkg::funct3And: aluOp = rvPkg::aluAnd;
					default:          aluOp = rvPkg::aluAdd; // Shifts etc. unsupported
				endcase
			end
			default: aluOp = rvPkg::aluAdd;
		endcase
	end

endmodule

//--- hw/immGen.sv
// Immediate generator for the I, S, B and U instruction formats
module immGen (
	input  rvPkg::instrWord instr,
	output logic [31:0]     imm
);

	always_comb begin
		case (instr.rType.opcode) // Opcode sits in the same place in every view
			rvPkg::opImm, rvPkg::opLoad: begin
				imm = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
			end
			rvPkg::opStore: begin
				// Split around rd position
				imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
			end
			rvPkg::opBranch: begin
				imm = {
					{19{instr.bType.immBit12}},
					instr.bType.immBit12,
					instr.bType.immBit11,
					instr.bType.immHi6,
					instr.bType.immLo4,
					1'b0 // Halfword aligned offset
				};
			end
			rvPkg::opLui, rvPkg::opAuipc: begin
				imm = {instr.uType.imm20, 12'h000};
			end
			default: imm = '0; // R form has no immediate
		endcase
	end

endmodule

//--- hw/mainControl.sv
// Main decoder turning the major opcode into the datapath control bundle
module mainControl (
	input  logic [6:0]       opcode,
	output rvPkg::ctrlBundle ctrl
);

	always_comb begin
		case (opcode)
			rvPkg::opR: begin // ADD, SUB, AND, OR, XOR, SLT
				ctrl = '{
					branch:   1'b0,
					memRead:  1'b0,
					memToReg: 1'b0,
					memWrite: 1'b0,
					regWrite: 1'b1,
					aluSrc:   1'b0,
					aluClass: rvPkg::aluClassR,
					srcASel:  rvPkg::srcARs1
				};
			end
			rvPkg::opImm: begin // ADDI and friends
				ctrl = '{
					branch:   1'b0,
					memRead:  1'b0,
					memToReg: 1'b0,
					memWrite: 1'b0,
					regWrite: 1'b1,
					aluSrc:   1'b1,
					aluClass: rvPkg::aluClassI,
					srcASel:  rvPkg::srcARs1
				};
			end
			rvPkg::opLoad: begin
				ctrl = '{
					branch:   1'b0,
					memRead:  1'b1, // Only loads read memory
					memToReg: 1'b1,
					memWrite: 1'b0,
					regWrite: 1'b1,
					aluSrc:   1'b1,
					aluClass: rvPkg::aluClassAdd,
					srcASel:  rvPkg::srcARs1
				};
			end
			rvPkg::opStore: begin
				ctrl = '{
					branch:   1'b0,
					memRead:  1'b0,
					memToReg: 1'b0,
					memWrite: 1'b1,
					regWrite: 1'b0,
					aluSrc:   1'b1,
					aluClass: rvPkg::aluClassAdd,
					srcASel:  rvPkg::srcARs1
				};
			end
			rvPkg::opBranch: begin
				ctrl = '{
					branch:   1'b1,
					memRead:  1'b0,
					memToReg: 1'b0,
					memWrite: 1'b0,
					regWrite: 1'b0,
					aluSrc:   1'b0, // Compare rs1 against rs2
					aluClass: rvPkg::aluClassBranch,
					srcASel:  rvPkg::srcARs1
				};
			end
			rvPkg::opLui, rvPkg::opAuipc: begin
				// Same row, differ only in operand A
				ctrl = '{
					branch:   1'b0,
					memRead:  1'b0,
					memToReg: 1'b0,
					memWrite: 1'b0,
					regWrite: 1'b1,
					aluSrc:   1'b1,
					aluClass: rvPkg::aluClassAdd,
					srcASel:  (opcode == rvPkg::opLui) ? rvPkg::srcAZero : rvPkg::srcAPc
				};
			end
			default: ctrl = '0; // Unknown opcode, no side effects
		endcase
	end

endmodule

//--- hw/regFile.sv
// Integer register file, two async read ports, one write port, x0 tied to zero
module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        wen,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [rvPkg::regCount];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < rvPkg::regCount; i++)
				regs[i] <= '0;
		end else if (wen && (rd != 5'd0)) begin // x0 never written
			regs[rd] <= wdata;
		end
	end

	// Async read ports straight from the array
	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

endmodule

//--- hw/rvCore.sv
// Single-cycle RV32I core top with PC, branch logic, operand muxes and write-back
module rvCore (
	input  logic          clk,
	input  logic          arstN,
	output logic [31:0]   imemAddr,
	input  logic [31:0]   imemData, // Same-cycle instruction fetch
	output rvPkg::dmemReq dmem,
	input  logic [31:0]   dmemRdata // Same-cycle load data
);

	logic [31:0]         pc;
	logic [31:0]         pcPlus4;
	logic [31:0]         pcBranch;
	logic [31:0]         pcNext;
	rvPkg::instrWord     instr;
	rvPkg::ctrlBundle    ctrl;
	rvPkg::aluOperationT aluOp;
	logic [31:0]         imm;
	logic [31:0]         rdata1;
	logic [31:0]         rdata2;
	logic [31:0]         srcA;
	logic [31:0]         srcB;
	logic [31:0]         aluResult;
	logic                aluZero;
	logic                branchTaken;
	logic [31:0]         wbData;

	// ------------------------------
	// Fetch
	// ------------------------------
	assign imemAddr = pc;
	assign instr    = imemData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= rvPkg::resetPc;
		else
			pc <= pcNext; // One instruction per edge
	end

	// ------------------------------
	// Decode
	// ------------------------------
	mainControl mainControl_i (
		.opcode (instr.rType.opcode),
		.ctrl   (ctrl)
	);

	aluControl aluControl_i (
		.aluClass (ctrl.aluClass),
		.funct3   (instr.rType.funct3),
		.funct7b5 (instr.rType.funct7[5]),
		.aluOp    (aluOp)
	);

	immGen immGen_i (
		.instr (instr),
		.imm   (imm)
	);

	regFile regFile_i (
		.clk    (clk),
		.arstN  (arstN),
		.rs1    (instr.rType.rs1),
		.rs2    (instr.rType.rs2),
		.rd     (instr.rType.rd),
		.wen    (ctrl.regWrite),
		.wdata  (wbData),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// ------------------------------
	// Execute
	// ------------------------------
	always_comb begin
		case (ctrl.srcASel)
			rvPkg::srcAPc:   srcA = pc;    // AUIPC
			rvPkg::srcAZero: srcA = 32'd0; // LUI passes imm through
			rvPkg::srcARs1:  srcA = rdata1;
			default:         srcA = 32'd0;
		endcase
	end

	assign srcB = ctrl.aluSrc ? imm : rdata2;

	alu alu_i (
		.a      (srcA),
		.b      (srcB),
		.op     (aluOp),
		.result (aluResult),
		.zero   (aluZero)
	);

	// Branch decision, BEQ and BNE only
	assign branchTaken = ctrl.branch &&
		(((instr.bType.funct3 == rvPkg::funct3Beq) && aluZero) ||
		 ((instr.bType.funct3 == rvPkg::funct3Bne) && !aluZero));

	assign pcPlus4  = pc + 32'd4;
	assign pcBranch = pc + imm; // B immediate already shifted
	assign pcNext   = branchTaken ? pcBranch : pcPlus4;

	// ------------------------------
	// Memory and write-back
	// ------------------------------
	assign dmem.addr  = aluResult;
	assign dmem.wdata = rdata2;         // Store data from rs2
	assign dmem.write = ctrl.memWrite;  // Commits at next edge in memory model
	assign dmem.read  = ctrl.memRead;

	assign wbData = ctrl.memToReg ? dmemRdata : aluResult;

endmodule

//--- hw/rvPkg.sv
// RV32I shared definitions for opcodes, ALU decode, instruction formats and bus bundles
package rvPkg;

	// ------------------------------
	// Architecture
	// ------------------------------
	localparam int regCount = 32;                    // x0..x31
	localparam logic [31:0] resetPc = 32'h0000_0000; // Boot address

	// ------------------------------
	// Major opcodes
	// ------------------------------
	localparam logic [6:0] opR      = 7'b0110011; // Register-register
	localparam logic [6:0] opImm    = 7'b0010011; // Register-immediate
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;

	// Branch conditions
	localparam logic [2:0] funct3Beq = 3'b000;
	localparam logic [2:0] funct3Bne = 3'b001;

	// Arithmetic funct3, shared by R and I forms
	localparam logic [2:0] funct3Add = 3'b000; // ADD, SUB, ADDI
	localparam logic [2:0] funct3Slt = 3'b010;
	localparam logic [2:0] funct3Xor = 3'b100;
	localparam logic [2:0] funct3Or  = 3'b110;
	localparam logic [2:0] funct3And = 3'b111;

	// ------------------------------
	// ALU decode
	// ------------------------------
	// First-level class from the main decoder
	typedef logic [3:0] aluClassT;
	localparam aluClassT aluClassR      = 4'b0000; // From funct3 and funct7
	localparam aluClassT aluClassI      = 4'b1100; // From funct3 only
	localparam aluClassT aluClassAdd    = 4'b0001; // Address and U-type sums
	localparam aluClassT aluClassBranch = 4'b1111; // Compare by subtract

	// Concrete operation seen by the ALU
	typedef logic [3:0] aluOperationT;
	localparam aluOperationT aluAdd = 4'd0;
	localparam aluOperationT aluSub = 4'd1;
	localparam aluOperationT aluAnd = 4'd2;
	localparam aluOperationT aluOr  = 4'd3;
	localparam aluOperationT aluXor = 4'd4;
	localparam aluOperationT aluSlt = 4'd5;

	// Operand A source
	typedef logic [1:0] srcASelT;
	localparam srcASelT srcAPc   = 2'b00; // AUIPC
	localparam srcASelT srcAZero = 2'b01; // LUI
	localparam srcASelT srcARs1  = 2'b10; // Everything else

	// ------------------------------
	// Instruction word, five views
	// ------------------------------
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iType;
		struct packed {
			logic [6:0] immHi; // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo; // imm[4:0]
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic       immBit12;
			logic [5:0] immHi6;   // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] immLo4;   // imm[4:1]
			logic       immBit11;
			logic [6:0] opcode;
		} bType;
		struct packed {
			logic [19:0] imm20;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} uType;
	} instrWord;

	// Control lines out of the main decoder
	typedef struct packed {
		logic     branch;
		logic     memRead;
		logic     memToReg;
		logic     memWrite;
		logic     regWrite;
		logic     aluSrc;   // Immediate as operand B
		aluClassT aluClass;
		srcASelT  srcASel;
	} ctrlBundle;

	// Data port request
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        write;
		logic        read;
	} dmemReq;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o simRvCore
./obj_dir/simRvCore +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

//--- rvCore.f
hw/rvPkg.sv
hw/mainControl.sv
hw/aluControl.sv
hw/immGen.sv
hw/alu.sv
hw/regFile.sv
hw/rvCore.sv
tb/rvCore_chk.sv
tb/rvCoreTb.sv

//--- tb/rvCoreTb.sv
// Testbench for the single-cycle core with program ROM, data RAM and store scoreboard
module rvCoreTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int storeCount    = 12;
	localparam int timeoutCycles = 200;
	localparam logic [31:0] auipcPc = 32'h0000_0040; // Word 16 of the program

	logic          clk;
	logic          arstN;
	logic [31:0]   imemAddr;
	logic [31:0]   imemData;
	rvPkg::dmemReq dmem;
	logic [31:0]   dmemRdata;

	logic [31:0] instrMem [32];
	logic [31:0] dataMem [256];
	logic [31:0] expAddr [storeCount];
	logic [31:0] expData [storeCount];
	string       expName [storeCount];
	logic [19:0] luiImm;       // Random upper immediate
	int          storeIdx;     // Next expected store

	rvCore dut_i (
		.clk       (clk),
		.arstN     (arstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.dmem      (dmem),
		.dmemRdata (dmemRdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------
	// Memory models
	// ------------------------------
	assign imemData  = arstN ? instrMem[imemAddr[6:2]] : 32'd0; // Zero word decodes to no-op
	assign dmemRdata = dataMem[dmem.addr[9:2]];

	// Store scoreboard committing at the edge
	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 256; i++)
				dataMem[i] <= 32'hDA00_0000 | (i * 4); // Fill tracks byte address
			storeIdx <= 0;
		end else if (dmem.write) begin
			if (storeIdx >= storeCount) begin
				$display("Store to %h beyond the end of the expected table", dmem.addr);
				$display("TESTBENCH FAILED");
				$fatal(1, "Unexpected store");
			end else if ((dmem.addr != expAddr[storeIdx]) ||
				(dmem.wdata != expData[storeIdx])) begin
				$display("[ERROR] %s: expected addr %h data %h, actual addr %h data %h",
					expName[storeIdx], expAddr[storeIdx], expData[storeIdx],
					dmem.addr, dmem.wdata);
				$display("TESTBENCH FAILED");
				$fatal(1, "Store mismatch");
			end else begin
				dataMem[dmem.addr[9:2]] <= dmem.wdata;
				storeIdx <= storeIdx + 1;
			end
		end
	end

	// Checker flags from the bound assertions
	always @(negedge clk) begin
		if (dut_i.chk_i.failed) begin
			$display("Assertion in the core checker failed");
			$display("TESTBENCH FAILED");
			$fatal(1, "Checker failure");
		end
	end

	// ------------------------------
	// Instruction encoders
	// ------------------------------
	function automatic logic [31:0] rInstr(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvPkg::opR};
	endfunction

	function automatic logic [31:0] iInstr(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] storeInstr(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore}; // SW
	endfunction

	function automatic logic [31:0] branchInstr(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opBranch};
	endfunction

	function automatic logic [31:0] upperInstr(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	task automatic loadProgram();
		instrMem[0]  = iInstr(12'd5, 5'd0, rvPkg::funct3Add, 5'd1, rvPkg::opImm); // x1 = 5
		instrMem[1]  = iInstr(12'd7, 5'd0, rvPkg::funct3Add, 5'd2, rvPkg::opImm); // x2 = 7
		instrMem[2]  = rInstr(7'd0, 5'd2, 5'd1, rvPkg::funct3Add, 5'd3);
		instrMem[3]  = storeInstr(12'h100, 5'd3, 5'd0);
		instrMem[4]  = rInstr(7'b0100000, 5'd2, 5'd1, rvPkg::funct3Add, 5'd4); // SUB
		instrMem[5]  = storeInstr(12'h104, 5'd4, 5'd0);
		instrMem[6]  = rInstr(7'd0, 5'd2, 5'd1, rvPkg::funct3And, 5'd5);
		instrMem[7]  = storeInstr(12'h108, 5'd5, 5'd0);
		instrMem[8]  = rInstr(7'd0, 5'd2, 5'd1, rvPkg::funct3Or, 5'd6);
		instrMem[9]  = storeInstr(12'h10C, 5'd6, 5'd0);
		instrMem[10] = rInstr(7'd0, 5'd2, 5'd1, rvPkg::funct3Xor, 5'd7);
		instrMem[11] = storeInstr(12'h110, 5'd7, 5'd0);
		instrMem[12] = rInstr(7'd0, 5'd2, 5'd1, rvPkg::funct3Slt, 5'd8);
		instrMem[13] = storeInstr(12'h114, 5'd8, 5'd0);
		instrMem[14] = upperInstr(luiImm, 5'd9, rvPkg::opLui);
		instrMem[15] = storeInstr(12'h118, 5'd9, 5'd0);
		instrMem[16] = upperInstr(20'h00001, 5'd10, rvPkg::opAuipc);
		instrMem[17] = storeInstr(12'h11C, 5'd10, 5'd0);
		instrMem[18] = iInstr(12'h100, 5'd0, 3'b010, 5'd11, rvPkg::opLoad); // LW of ADD result
		instrMem[19] = iInstr(12'd1, 5'd11, rvPkg::funct3Add, 5'd11, rvPkg::opImm);
		instrMem[20] = storeInstr(12'h120, 5'd11, 5'd0);
		// Marker has imm bit 10 set where R form keeps its SUB select
		instrMem[21] = iInstr(12'h455, 5'd0, rvPkg::funct3Add, 5'd12, rvPkg::opImm);
		instrMem[22] = branchInstr(13'd8, 5'd1, 5'd1, rvPkg::funct3Beq); // Taken
		instrMem[23] = iInstr(12'h066, 5'd0, rvPkg::funct3Add, 5'd12, rvPkg::opImm); // Poison
		instrMem[24] = storeInstr(12'h124, 5'd12, 5'd0);
		instrMem[25] = branchInstr(13'd8, 5'd1, 5'd1, rvPkg::funct3Bne); // Falls through
		instrMem[26] = iInstr(12'h077, 5'd0, rvPkg::funct3Add, 5'd13, rvPkg::opImm);
		instrMem[27] = storeInstr(12'h128, 5'd13, 5'd0);
		instrMem[28] = iInstr(12'h099, 5'd0, rvPkg::funct3Add, 5'd0, rvPkg::opImm); // Into x0
		instrMem[29] = storeInstr(12'h12C, 5'd0, 5'd0);
		instrMem[30] = branchInstr(13'd0, 5'd0, 5'd0, rvPkg::funct3Beq); // Halt loop
		instrMem[31] = branchInstr(13'd0, 5'd0, 5'd0, rvPkg::funct3Beq);
	endtask

	// Expected stores with x1 = 5 and x2 = 7
	task automatic buildExpectedStores();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'd5;
		b = 32'd7;
		for (int k = 0; k < storeCount; k++)
			expAddr[k] = 32'h100 + (k * 4);
		expData[0]  = a + b;
		expData[1]  = a - b;
		expData[2]  = a & b;
		expData[3]  = a | b;
		expData[4]  = a ^ b;
		expData[5]  = 32'd1; // 5 < 7
		expData[6]  = {luiImm, 12'h000};
		expData[7]  = auipcPc + {20'h00001, 12'h000};
		expData[8]  = (a + b) + 32'd1;
		expData[9]  = 32'h455; // Poison never lands
		expData[10] = 32'h77;
		expData[11] = 32'd0;
		expName = '{"ADD", "SUB", "AND", "OR", "XOR", "SLT", "LUI", "AUIPC",
			"LW+1", "BEQ skip", "BNE fall", "x0 write"};
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int cycles;
		luiImm  = 20'($urandom(68)); // Seeded draw
		arstN   = 1'b0;
		loadProgram();
		buildExpectedStores();
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		cycles = 0;
		while ((storeIdx < storeCount) && (cycles < timeoutCycles)) begin
			@(posedge clk);
			cycles++;
		end
		if ((storeIdx == storeCount) && !dut_i.chk_i.failed) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Timed out after %0d cycles waiting for store %0d", cycles, storeIdx);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout");
		end
	end

endmodule

//--- tb/rvCore_chk.sv
// Concurrent checker for PC sequencing, branch targets, x0 reads and data-port strobes
module rvCoreChk (
	input logic            clk,
	input logic            arstN,
	input logic [31:0]     pc,
	input logic [31:0]     imemAddr,
	input rvPkg::instrWord instr,
	input rvPkg::dmemReq   dmem,
	input logic [31:0]     rdata1,
	input logic [31:0]     rdata2
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] raw;      // Plain bit view of the fetched word
	logic [31:0] bImm;     // Branch offset rebuilt from raw bits
	logic        isBranch;
	logic        takeExp;  // Expected branch decision from register values
	logic        badReset = 1'b0;
	logic        badQuiet = 1'b0;
	logic        badSeq   = 1'b0;
	logic        badJump  = 1'b0;
	logic        badStrb  = 1'b0;
	logic        badX0    = 1'b0;
	logic        failed;   // Watched by the testbench

	assign raw      = instr;
	assign bImm     = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
	assign isBranch = (raw[6:0] == rvPkg::opBranch);
	assign takeExp  = isBranch &&
		(((raw[14:12] == rvPkg::funct3Beq) && (rdata1 == rdata2)) ||
		 ((raw[14:12] == rvPkg::funct3Bne) && (rdata1 != rdata2)));
	assign failed   = badReset | badQuiet | badSeq | badJump | badStrb | badX0;

	// ------------------------------
	// Reset behaviour
	// ------------------------------
	resetVectorA: assert property (@(posedge clk)
		$rose(arstN) |-> imemAddr == rvPkg::resetPc)
		else begin
			badReset = 1'b1;
			$error("PC is not at the reset vector after release");
		end

	resetQuietA: assert property (@(posedge clk) !arstN |-> (!dmem.write && !dmem.read))
		else begin
			badQuiet = 1'b1;
			$error("Data port strobe active during reset");
		end

	// ------------------------------
	// Next PC
	// ------------------------------
	// Release edge excluded, the PC still sits at the reset vector after it
	seqPcA: assert property (@(posedge clk) disable iff (!arstN)
		(arstN && !takeExp) |=> pc == $past(pc) + 32'd4)
		else begin
			badSeq = 1'b1;
			$error("PC did not advance by 4");
		end

	branchPcA: assert property (@(posedge clk) disable iff (!arstN)
		takeExp |=> pc == $past(pc) + $past(bImm))
		else begin
			badJump = 1'b1;
			$error("Taken branch missed its target");
		end

	// Strobes follow the load and store opcodes only
	strobeA: assert property (@(posedge clk)
		(dmem.read == (raw[6:0] == rvPkg::opLoad)) &&
		(dmem.write == (raw[6:0] == rvPkg::opStore)))
		else begin
			badStrb = 1'b1;
			$error("Data port strobe does not match the opcode");
		end

	x0ReadA: assert property (@(posedge clk) disable iff (!arstN)
		((raw[19:15] != 5'd0) || (rdata1 == 32'd0)) &&
		((raw[24:20] != 5'd0) || (rdata2 == 32'd0)))
		else begin
			badX0 = 1'b1;
			$error("Register x0 read back nonzero");
		end

endmodule

bind rvCore rvCoreChk chk_i (
	.clk      (clk),
	.arstN    (arstN),
	.pc       (pc),
	.imemAddr (imemAddr),
	.instr    (instr),
	.dmem     (dmem),
	.rdata1   (rdata1),
	.rdata2   (rdata2)
);
